/* Bender.yml */
package:
  name: apb_gpio

sources:
  - include_dirs:
      - include
    files:
      - hdl/gpio_pkg.sv
      - hdl/gpio_in_sampler.sv
      - hdl/gpio_irq_ctrl.sv
      - hdl/gpio_apb_regs.sv
      - hdl/apb_gpio.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_apb_gpio.sv

/* apb_gpio.f */
+incdir+include
hdl/gpio_pkg.sv
hdl/gpio_in_sampler.sv
hdl/gpio_irq_ctrl.sv
hdl/gpio_apb_regs.sv
hdl/apb_gpio.sv
bench/tb_apb_gpio.sv

/* bench/tb_apb_gpio.sv */
`timescale 1ns/1ns
`include "gpio_cfg.svh"

module tb_apb_gpio;

    localparam int HALF_PERIOD   = 20;
    localparam int SAMPLE_DELAY  = 10;     // Mid low phase with outputs settled
    localparam int READY_LIMIT   = 16;
    localparam int RESET_LIMIT   = 32;

    localparam logic [4:0] IDX_PADDIR    = 5'd0;
    localparam logic [4:0] IDX_GPIOEN    = 5'd1;
    localparam logic [4:0] IDX_PADIN     = 5'd2;
    localparam logic [4:0] IDX_PADOUT    = 5'd3;
    localparam logic [4:0] IDX_OUTSET    = 5'd4;
    localparam logic [4:0] IDX_OUTCLR    = 5'd5;
    localparam logic [4:0] IDX_INTEN     = 5'd6;
    localparam logic [4:0] IDX_TYPE_LO   = 5'd7;
    localparam logic [4:0] IDX_TYPE_HI   = 5'd8;
    localparam logic [4:0] IDX_INTSTATUS = 5'd9;

    logic                    HCLK;
    logic                    HRESETn;
    logic                    PSEL;
    logic                    PENABLE;
    logic                    PWRITE;
    logic [`GPIO_APB_AW-1:0] PADDR;
    logic [`GPIO_DATA_W-1:0] PWDATA;
    logic [`GPIO_DATA_W-1:0] PRDATA;
    logic                    PREADY;
    logic                    PSLVERR;
    logic [31:0]             gpio_in;
    logic [31:0]             gpio_out;
    logic [31:0]             gpio_dir;
    logic                    interrupt;

    // Reference model state
    logic [31:0] m_dir;
    logic [31:0] m_out;
    logic [31:0] m_en;
    logic [31:0] m_inten;
    logic [31:0] m_status;
    logic [31:0] m_s0;
    logic [31:0] m_s1;
    logic [31:0] m_hist;
    logic [1:0]  m_type [0:31];

    logic [31:0] lcg_state;
    int          mismatch_errors;
    int          other_errors;
    int          irq_cycles;

    apb_gpio dut0 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_dir  (gpio_dir),
        .interrupt (interrupt)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #HALF_PERIOD HCLK = ~HCLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper halves of two steps since low LCG bits are weak
    function automatic logic [31:0] rand32();
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_next();
        b = lcg_next();
        return {a[31:16], b[31:16]};
    endfunction

    // Edge matches per pad from the model pipeline
    function automatic logic [31:0] model_match();
        logic [31:0] m;
        logic        r;
        logic        f;
        for (int i = 0; i < 32; i++)
        begin
            r = m_s1[i] & ~m_hist[i];
            f = ~m_s1[i] & m_hist[i];
            case (m_type[i])
                2'd0:    m[i] = f;
                2'd1:    m[i] = r;
                2'd2:    m[i] = r | f;
                default: m[i] = 1'b0;
            endcase
            m[i] = m[i] & m_inten[i];
        end
        return m;
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] idx);
        logic [31:0] d;
        d = '0;
        case (idx)
            IDX_PADDIR:    d = m_dir;
            IDX_GPIOEN:    d = m_en;
            IDX_PADIN:     d = m_hist;
            IDX_PADOUT,
            IDX_OUTSET,
            IDX_OUTCLR:    d = m_out;
            IDX_INTEN:     d = m_inten;
            IDX_TYPE_LO:   for (int i = 0; i < 16; i++) d[2*i +: 2] = m_type[i];
            IDX_TYPE_HI:   for (int i = 0; i < 16; i++) d[2*i +: 2] = m_type[i+16];
            IDX_INTSTATUS: d = m_status;
            default:       d = '0;
        endcase
        return d;
    endfunction

    task automatic reset_model();
        m_dir    = `GPIO_DIR_RESET;
        m_out    = '0;
        m_en     = '0;
        m_inten  = '0;
        m_status = '0;
        m_s0     = '0;
        m_s1     = '0;
        m_hist   = '0;
        for (int i = 0; i < 32; i++)
        begin
            m_type[i] = 2'd0;
        end
    endtask

    // One clock edge of the model driven from the bus pins
    task automatic step_model();
        logic [31:0] match;
        logic [4:0]  idx;
        logic        acc;
        match = model_match();
        acc   = PSEL && PENABLE;
        idx   = PADDR[6:2];
        if (match != '0)
            m_status = m_status | match;   // Set wins over the read clear
        else if (acc && !PWRITE && idx == IDX_INTSTATUS)
            m_status = '0;
        for (int i = 0; i < 32; i++)
        begin
            if (m_en[i])
            begin
                m_hist[i] = m_s1[i];
                m_s1[i]   = m_s0[i];
                m_s0[i]   = gpio_in[i];
            end
        end
        if (acc && PWRITE)
        begin
            case (idx)
                IDX_PADDIR:  m_dir   = PWDATA;
                IDX_GPIOEN:  m_en    = PWDATA;
                IDX_PADOUT:  m_out   = PWDATA;
                IDX_OUTSET:  m_out   = m_out | PWDATA;
                IDX_OUTCLR:  m_out   = m_out & ~PWDATA;
                IDX_INTEN:   m_inten = PWDATA;
                IDX_TYPE_LO: for (int i = 0; i < 16; i++) m_type[i] = PWDATA[2*i +: 2];
                IDX_TYPE_HI: for (int i = 0; i < 16; i++) m_type[i+16] = PWDATA[2*i +: 2];
                default:     ;
            endcase
        end
    endtask

    always @(posedge HCLK)
    begin
        if (!HRESETn)
            reset_model();
        else
            step_model();
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Pad outputs and interrupt against the model every cycle
    always @(negedge HCLK)
    begin
        if (HRESETn)
        begin
            check_eq("gpio_dir", gpio_dir, m_dir);
            check_eq("gpio_out", gpio_out, m_out);
            check_eq("interrupt", {31'd0, interrupt}, {31'd0, |model_match()});
            if (interrupt === 1'b1)
                irq_cycles++;
        end
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (HRESETn !== 1'b1 && cycles < RESET_LIMIT)
        begin
            @(negedge HCLK);
            cycles++;
        end
        if (HRESETn !== 1'b1)
        begin
            other_errors++;
            $display("Reset was never released within %0d cycles", RESET_LIMIT);
            finish_run();
        end
    endtask

    // Called in the access phase and returns at the sample point
    task automatic wait_pready();
        int cycles;
        cycles = 0;
        #SAMPLE_DELAY;
        while (PREADY !== 1'b1 && cycles < READY_LIMIT)
        begin
            @(negedge HCLK);
            #SAMPLE_DELAY;
            cycles++;
        end
        if (PREADY !== 1'b1)
        begin
            other_errors++;
            $display("APB slave did not raise PREADY within %0d cycles", READY_LIMIT);
            finish_run();
        end
    endtask

    task automatic apb_setup(input logic [4:0] idx, input logic write,
                             input logic [31:0] data);
        logic [31:0] r;
        r = rand32();
        @(negedge HCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = {r[4:0], idx, 2'b00};   // Upper bits are don't care
        PWDATA  = data;
        @(negedge HCLK);
        PENABLE = 1'b1;
    endtask

    task automatic apb_idle();
        @(negedge HCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] idx, input logic [31:0] data);
        apb_setup(idx, 1'b1, data);
        wait_pready();
        apb_idle();
    endtask

    task automatic apb_read(input logic [4:0] idx, output logic [31:0] data,
                            output logic [31:0] exp);
        apb_setup(idx, 1'b0, rand32());
        wait_pready();
        data = PRDATA;
        exp  = model_read(idx);
        check_eq("PSLVERR", {31'd0, PSLVERR}, 32'd0);
        apb_idle();
    endtask

    task automatic read_check(input logic [4:0] idx, output logic [31:0] data);
        logic [31:0] exp;
        apb_read(idx, data, exp);
        check_eq($sformatf("PRDATA[idx %0d]", idx), data, exp);
    endtask

    initial
    begin
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] old_padin;
        logic [31:0] new_in;
        logic [4:0]  wr_idx [0:3];

        lcg_state       = 32'd53802;
        mismatch_errors = 0;
        other_errors    = 0;
        irq_cycles      = 0;
        HRESETn = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        gpio_in = '0;
        wr_idx[0] = IDX_PADDIR;
        wr_idx[1] = IDX_PADOUT;
        wr_idx[2] = IDX_OUTSET;
        wr_idx[3] = IDX_OUTCLR;

        repeat (16) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        wait_reset_release();

        // Reset values of the whole map
        for (int i = 0; i <= 9; i++)
        begin
            apb_read(i[4:0], data, exp);
            exp = (i == 0) ? `GPIO_DIR_RESET : 32'd0;
            check_eq($sformatf("reset PRDATA[idx %0d]", i), data, exp);
        end
        check_eq("gpio_dir", gpio_dir, `GPIO_DIR_RESET);
        check_eq("gpio_out", gpio_out, 32'd0);
        check_eq("interrupt", {31'd0, interrupt}, 32'd0);
        check_eq("PREADY", {31'd0, PREADY}, 32'd1);
        check_eq("PSLVERR", {31'd0, PSLVERR}, 32'd0);

        // Direction and output with set and clear aliases
        for (int n = 0; n < 40; n++)
        begin
            data = rand32();
            apb_write(wr_idx[data[1:0]], rand32());
            read_check(wr_idx[data[3:2]], data);
        end

        // Input sampling through the enable mask
        for (int n = 0; n < 8; n++)
        begin
            apb_write(IDX_GPIOEN, rand32());
            read_check(IDX_PADIN, old_padin);
            new_in = rand32();
            @(negedge HCLK);
            gpio_in = new_in;
            repeat (2) @(posedge HCLK);       // Third edge lands inside the read
            read_check(IDX_PADIN, data);
            check_eq("PADIN", data, (new_in & m_en) | (old_padin & ~m_en));
        end

        // Edge interrupts and sticky status
        apb_write(IDX_GPIOEN, rand32());
        apb_write(IDX_INTEN, rand32());
        apb_write(IDX_TYPE_LO, rand32());
        apb_write(IDX_TYPE_HI, rand32());
        read_check(IDX_TYPE_LO, data);
        read_check(IDX_TYPE_HI, data);
        read_check(IDX_INTSTATUS, data);
        irq_cycles = 0;
        for (int n = 0; n < 80; n++)
        begin
            @(negedge HCLK);
            gpio_in = gpio_in ^ rand32();
            if (n % 10 == 9)
                read_check(IDX_INTSTATUS, data);
        end
        repeat (4) @(posedge HCLK);       // Let the pipeline settle
        read_check(IDX_INTSTATUS, data);
        read_check(IDX_INTSTATUS, data);
        check_eq("INTSTATUS after clear", data, 32'd0);
        assert (irq_cycles > 0)
        else
        begin
            other_errors++;
            $display("No interrupt was raised while the pad inputs toggled");
        end

        // Unmapped words read zero and hold no state
        for (int i = 10; i < 32; i++)
        begin
            apb_read(i[4:0], data, exp);
            check_eq($sformatf("unmapped PRDATA[idx %0d]", i), data, 32'd0);
            apb_write(i[4:0], rand32());
        end
        for (int i = 0; i <= 9; i++)
        begin
            read_check(i[4:0], data);
        end

        finish_run();
    end

endmodule

/* hdl/apb_gpio.sv */
`timescale 1ns/1ns
`include "gpio_cfg.svh"

module apb_gpio
    import gpio_pkg::*;
(
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [`GPIO_APB_AW-1:0] PADDR,
    input  logic [`GPIO_DATA_W-1:0] PWDATA,
    output logic [`GPIO_DATA_W-1:0] PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    input  pad_vec_t                gpio_in,
    output pad_vec_t                gpio_out,
    output pad_vec_t                gpio_dir,
    output logic                    interrupt
);

    apb_req_t   apb_req;
    gpio_ctrl_t ctrl;
    pad_vec_t   pad_in;
    pad_vec_t   rise;
    pad_vec_t   fall;
    pad_vec_t   status;
    logic       status_rd;

    assign apb_req.sel    = PSEL;
    assign apb_req.enable = PENABLE;
    assign apb_req.write  = PWRITE;
    assign apb_req.idx    = PADDR[6:2];   // Word aligned register index
    assign apb_req.wdata  = PWDATA;

    // Zero wait states, never an error
    assign PREADY  = 1'b1;
    assign PSLVERR = 1'b0;

    assign gpio_out = ctrl.out;
    assign gpio_dir = ctrl.dir;

    gpio_apb_regs u_regs (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .apb       (apb_req),
        .pad_in    (pad_in),
        .status    (status),
        .ctrl      (ctrl),
        .prdata    (PRDATA),
        .status_rd (status_rd)
    );

    gpio_in_sampler u_sampler (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .gpio_in (gpio_in),
        .ctrl    (ctrl),
        .pad_in  (pad_in),
        .rise    (rise),
        .fall    (fall)
    );

    gpio_irq_ctrl u_irq (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .ctrl      (ctrl),
        .rise      (rise),
        .fall      (fall),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

endmodule

/* hdl/gpio_apb_regs.sv */
`timescale 1ns/1ns
`include "gpio_cfg.svh"

module gpio_apb_regs
    import gpio_pkg::*;
(
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  apb_req_t                apb,
    input  pad_vec_t                pad_in,
    input  pad_vec_t                status,
    output gpio_ctrl_t              ctrl,
    output logic [`GPIO_DATA_W-1:0] prdata,
    output logic                    status_rd
);

    localparam int HALF = `GPIO_PAD_NUM / 2;   // Pads per INTTYPE word

    logic access;
    logic wr;
    logic rd;

    assign access = apb.sel & apb.enable;    // APB access phase
    assign wr     = access &  apb.write;
    assign rd     = access & ~apb.write;

    assign status_rd = rd && (apb.idx == `GPIO_REG_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            ctrl.dir   <= `GPIO_DIR_RESET;
            ctrl.out   <= '0;
            ctrl.en    <= '0;
            ctrl.inten <= '0;
            for (int i = 0; i < `GPIO_PAD_NUM; i++)
            begin
                ctrl.inttype[i] <= INT_FALL;
            end
        end
        else if (wr)
        begin
            case (apb.idx)
                `GPIO_REG_PADDIR:    ctrl.dir   <= apb.wdata;
                `GPIO_REG_GPIOEN:    ctrl.en    <= apb.wdata;
                `GPIO_REG_PADOUT:    ctrl.out   <= apb.wdata;
                `GPIO_REG_PADOUTSET: ctrl.out   <= ctrl.out | apb.wdata;
                `GPIO_REG_PADOUTCLR: ctrl.out   <= ctrl.out & ~apb.wdata;
                `GPIO_REG_INTEN:     ctrl.inten <= apb.wdata;
                `GPIO_REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < HALF; i++)
                    begin
                        ctrl.inttype[i] <= int_type_e'(apb.wdata[2*i +: 2]);
                    end
                end
                `GPIO_REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < HALF; i++)
                    begin
                        ctrl.inttype[i+HALF] <= int_type_e'(apb.wdata[2*i +: 2]);
                    end
                end
                default:
                begin
                    // PADIN, INTSTATUS and unmapped words are read only
                end
            endcase
        end
    end

    // Read mux, zero outside the access phase
    always_comb
    begin
        prdata = '0;
        if (rd)
        begin
            case (apb.idx)
                `GPIO_REG_PADDIR:    prdata = ctrl.dir;
                `GPIO_REG_GPIOEN:    prdata = ctrl.en;
                `GPIO_REG_PADIN:     prdata = pad_in;
                `GPIO_REG_PADOUT:    prdata = ctrl.out;
                `GPIO_REG_PADOUTSET: prdata = ctrl.out;
                `GPIO_REG_PADOUTCLR: prdata = ctrl.out;
                `GPIO_REG_INTEN:     prdata = ctrl.inten;
                `GPIO_REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < HALF; i++)
                    begin
                        prdata[2*i +: 2] = ctrl.inttype[i];
                    end
                end
                `GPIO_REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < HALF; i++)
                    begin
                        prdata[2*i +: 2] = ctrl.inttype[i+HALF];
                    end
                end
                `GPIO_REG_INTSTATUS: prdata = status;
                default:             prdata = '0;
            endcase
        end
    end

    // Bus master must present clean data on a write
    a_wdata_known: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        wr |-> !$isunknown(apb.wdata)
    );

endmodule

/* hdl/gpio_in_sampler.sv */
`timescale 1ns/1ns
`include "gpio_cfg.svh"

module gpio_in_sampler
    import gpio_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  pad_vec_t   gpio_in,
    input  gpio_ctrl_t ctrl,
    output pad_vec_t   pad_in,
    output pad_vec_t   rise,
    output pad_vec_t   fall
);

    pad_vec_t sync0;
    pad_vec_t sync1;
    pad_vec_t hist;     // Last sampled value read back at PADIN

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0 <= '0;
            sync1 <= '0;
            hist  <= '0;
        end
        else
        begin
            for (int i = 0; i < `GPIO_PAD_NUM; i++)
            begin
                // Disabled pad keeps all three stages frozen
                if (ctrl.en[i])
                begin
                    sync0[i] <= gpio_in[i];
                    sync1[i] <= sync0[i];
                    hist[i]  <= sync1[i];
                end
            end
        end
    end

    assign pad_in = hist;
    assign rise   =  sync1 & ~hist;
    assign fall   = ~sync1 &  hist;

    // Enabled pads must carry clean levels
    a_in_known: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !$isunknown(gpio_in & ctrl.en)
    );

endmodule

/* hdl/gpio_irq_ctrl.sv */
`timescale 1ns/1ns
`include "gpio_cfg.svh"

module gpio_irq_ctrl
    import gpio_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  gpio_ctrl_t ctrl,
    input  pad_vec_t   rise,
    input  pad_vec_t   fall,
    input  logic       status_rd,
    output pad_vec_t   status,
    output logic       interrupt
);

    pad_vec_t match;
    logic     any_match;

    // Edge kind selected per pad
    always_comb
    begin
        for (int i = 0; i < `GPIO_PAD_NUM; i++)
        begin
            case (ctrl.inttype[i])
                INT_FALL: match[i] = fall[i];
                INT_RISE: match[i] = rise[i];
                INT_BOTH: match[i] = rise[i] | fall[i];
                default:  match[i] = 1'b0;
            endcase
            match[i] = match[i] & ctrl.inten[i];
        end
    end

    assign any_match = |match;
    assign interrupt = any_match;

    // Sticky status, a new event wins over the read clear
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status <= '0;
        end
        else if (any_match)
        begin
            status <= status | match;
        end
        else if (status_rd)
        begin
            status <= '0;
        end
    end

    // Bits only drop after an INTSTATUS read
    a_status_sticky: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !status_rd |=> ((status & $past(status)) == $past(status))
    );

endmodule

/* hdl/gpio_pkg.sv */
`include "gpio_cfg.svh"

package gpio_pkg;

    typedef logic [`GPIO_PAD_NUM-1:0] pad_vec_t;

    // Edge kind per pad, code 3 never fires
    typedef enum logic [1:0]
    {
        INT_FALL = 2'd0,
        INT_RISE = 2'd1,
        INT_BOTH = 2'd2
    } int_type_e;

    // APB pins as seen by the register block
    typedef struct packed
    {
        logic                       sel;
        logic                       enable;
        logic                       write;
        logic [`GPIO_REG_IDX_W-1:0] idx;
        logic [`GPIO_DATA_W-1:0]    wdata;
    } apb_req_t;

    typedef struct packed
    {
        pad_vec_t                        dir;
        pad_vec_t                        out;
        pad_vec_t                        en;
        pad_vec_t                        inten;
        int_type_e [`GPIO_PAD_NUM-1:0]   inttype;
    } gpio_ctrl_t;

endpackage

/* include/gpio_cfg.svh */
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// Bus and pad dimensions
`define GPIO_PAD_NUM   32
`define GPIO_APB_AW    12
`define GPIO_DATA_W    32

// Word index taken from PADDR[6:2]
`define GPIO_REG_IDX_W 5

// Register map as word indices
`define GPIO_REG_PADDIR      5'd0
`define GPIO_REG_GPIOEN      5'd1
`define GPIO_REG_PADIN       5'd2
`define GPIO_REG_PADOUT      5'd3
`define GPIO_REG_PADOUTSET   5'd4
`define GPIO_REG_PADOUTCLR   5'd5
`define GPIO_REG_INTEN       5'd6
`define GPIO_REG_INTTYPE_LO  5'd7
`define GPIO_REG_INTTYPE_HI  5'd8
`define GPIO_REG_INTSTATUS   5'd9

// Pads 0 to 9 come out of reset as outputs
`define GPIO_DIR_RESET 32'h0000_03FF

`endif
